/* design/fifo_settings.svh */
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// bits per stored word
`define FIFO_DATA_WIDTH 8

// number of words, kept a power of two so the pointers wrap cleanly
`define FIFO_DEPTH 16
`define FIFO_ADDR_WIDTH 4

// afull when used >= FIFO_AFULL in the write domain
`define FIFO_AFULL 14
// aempty when used <= FIFO_AEMPTY in the read domain
`define FIFO_AEMPTY 2

`endif

/* design/fifo_ptr_pkg.sv */
`include "fifo_settings.svh"

package fifo_ptr_pkg;

  // wrap bit above the RAM address, set on every second pass
  typedef struct packed {
    logic                        wrap;
    logic [`FIFO_ADDR_WIDTH-1:0] addr;
  } fifo_ptr_fields_t;

  // raw view for Gray coding and subtraction, field view for addressing
  typedef union packed {
    logic [`FIFO_ADDR_WIDTH:0] raw;
    fifo_ptr_fields_t          fld;
  } fifo_ptr_u;

  function automatic fifo_ptr_u bin_to_gray(input fifo_ptr_u bin);
    fifo_ptr_u gray;
    gray.raw = bin.raw ^ (bin.raw >> 1);
    return gray;
  endfunction

  function automatic fifo_ptr_u gray_to_bin(input fifo_ptr_u gray);
    fifo_ptr_u bin;
    bin.raw[`FIFO_ADDR_WIDTH] = gray.raw[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin.raw[i] = bin.raw[i+1] ^ gray.raw[i]; // each bit folds in all the bits above it
    end
    return bin;
  endfunction

endpackage

/* design/fifo_data_pkg.sv */
`include "fifo_settings.svh"

package fifo_data_pkg;

  // one entry of the FIFO payload
  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_word_t;

endpackage

/* design/dual_port_ram.sv */
`include "fifo_settings.svh"

module dual_port_ram (
  input  logic                        wr_clk,
  input  logic                        wr_en,
  input  logic [`FIFO_ADDR_WIDTH-1:0] wr_addr,
  input  fifo_data_pkg::fifo_word_t   wr_data,
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,
  input  logic                        rd_en,
  input  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
  output fifo_data_pkg::fifo_word_t   rd_data
);

  import fifo_data_pkg::*;

  fifo_word_t mem [`FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read register holds its word until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* design/gray_ptr_counter.sv */
`include "fifo_settings.svh"

module gray_ptr_counter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    accept,
  output fifo_ptr_pkg::fifo_ptr_u ptr,
  output fifo_ptr_pkg::fifo_ptr_u ptr_nxt,
  output fifo_ptr_pkg::fifo_ptr_u gray
);

  import fifo_ptr_pkg::*;

  fifo_ptr_u gray_nxt;

  // one extra bit lets the pointer run over twice the depth before it wraps
  always_comb begin
    ptr_nxt.raw = ptr.raw + {{`FIFO_ADDR_WIDTH{1'b0}}, accept};
    gray_nxt    = bin_to_gray(ptr_nxt);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else begin
      ptr <= ptr_nxt;
    end
  end

  // registered so the other domain never samples a decoder glitch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray <= '0;
    end else begin
      gray <= gray_nxt;
    end
  end

endmodule

/* design/wr_flag_logic.sv */
`include "fifo_settings.svh"

module wr_flag_logic (
  input  logic                    wr_clk,
  input  logic                    wr_rst_n,
  input  fifo_ptr_pkg::fifo_ptr_u wr_ptr_nxt,
  input  fifo_ptr_pkg::fifo_ptr_u rd_gray,
  output logic                    full,
  output logic                    afull
);

  import fifo_ptr_pkg::*;

  fifo_ptr_u                 rd_gray_s1;
  fifo_ptr_u                 rd_gray_s2;
  fifo_ptr_u                 rd_bin;
  logic [`FIFO_ADDR_WIDTH:0] used;
  logic                      full_nxt;
  logic                      afull_nxt;

  // two stage synchronizer for the read pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_comb begin
    rd_bin = gray_to_bin(rd_gray_s2);
    used   = wr_ptr_nxt.raw - rd_bin.raw;
    // same address one lap ahead means every slot is taken
    full_nxt  = (wr_ptr_nxt.fld.wrap != rd_bin.fld.wrap) &&
                (wr_ptr_nxt.fld.addr == rd_bin.fld.addr);
    afull_nxt = used >= (`FIFO_ADDR_WIDTH + 1)'(`FIFO_AFULL);
  end

  // used count is pessimistic here since the read pointer lags
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

/* design/rd_flag_logic.sv */
`include "fifo_settings.svh"

module rd_flag_logic (
  input  logic                    rd_clk,
  input  logic                    rd_rst_n,
  input  fifo_ptr_pkg::fifo_ptr_u rd_ptr_nxt,
  input  fifo_ptr_pkg::fifo_ptr_u wr_gray,
  output logic                    empty,
  output logic                    aempty
);

  import fifo_ptr_pkg::*;

  fifo_ptr_u                 wr_gray_s1;
  fifo_ptr_u                 wr_gray_s2;
  fifo_ptr_u                 wr_bin;
  logic [`FIFO_ADDR_WIDTH:0] used;
  logic                      empty_nxt;
  logic                      aempty_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;    // first stage may go metastable
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_comb begin
    wr_bin     = gray_to_bin(wr_gray_s2);
    used       = wr_bin.raw - rd_ptr_nxt.raw;
    empty_nxt  = (rd_ptr_nxt.raw == wr_bin.raw); // wrap bits match too, so nothing is stored
    aempty_nxt = used <= (`FIFO_ADDR_WIDTH + 1)'(`FIFO_AEMPTY);
  end

  // FIFO comes out of reset empty
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

/* design/async_fifo.sv */
module async_fifo (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      wr_en,
  input  fifo_data_pkg::fifo_word_t wr_data,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  logic                      rd_en,
  output fifo_data_pkg::fifo_word_t rd_data,
  output logic                      full,
  output logic                      empty,
  output logic                      afull,
  output logic                      aempty
);

  import fifo_ptr_pkg::*;

  logic      wr_accept;
  logic      rd_accept;
  fifo_ptr_u wr_ptr;
  fifo_ptr_u wr_ptr_nxt;
  fifo_ptr_u wr_gray;
  fifo_ptr_u rd_ptr;
  fifo_ptr_u rd_ptr_nxt;
  fifo_ptr_u rd_gray;

  assign wr_accept = wr_en && !full;  // writes into a full FIFO are dropped
  assign rd_accept = rd_en && !empty;

  dual_port_ram ram_i (
    .wr_clk   (wr_clk),
    .wr_en    (wr_accept),
    .wr_addr  (wr_ptr.fld.addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_accept),
    .rd_addr  (rd_ptr.fld.addr),
    .rd_data  (rd_data)
  );

  gray_ptr_counter wr_cnt_i (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .accept  (wr_accept),
    .ptr     (wr_ptr),
    .ptr_nxt (wr_ptr_nxt),
    .gray    (wr_gray)
  );

  gray_ptr_counter rd_cnt_i (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .accept  (rd_accept),
    .ptr     (rd_ptr),
    .ptr_nxt (rd_ptr_nxt),
    .gray    (rd_gray)
  );

  // only the Gray pointers cross between the clock domains
  wr_flag_logic wr_flag_i (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .wr_ptr_nxt (wr_ptr_nxt),
    .rd_gray    (rd_gray),
    .full       (full),
    .afull      (afull)
  );

  rd_flag_logic rd_flag_i (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .rd_ptr_nxt (rd_ptr_nxt),
    .wr_gray    (wr_gray),
    .empty      (empty),
    .aempty     (aempty)
  );

endmodule

/* tb/tb_clocks.sv */
module tb_clocks (
  output logic wr_clk,
  output logic wr_rst_n,
  output logic rd_clk,
  output logic rd_rst_n
);

  // the two periods never put a write edge and a read edge at the same time
  initial begin
    wr_clk = 1'b0;
    forever #35 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #50 rd_clk = ~rd_clk;
  end

  initial begin
    wr_rst_n = 1'b0;
    repeat (4) @(posedge wr_clk);
    #5;
    wr_rst_n = 1'b1;
  end

  initial begin
    rd_rst_n = 1'b0;
    repeat (4) @(posedge rd_clk);
    #5;
    rd_rst_n = 1'b1;
  end

endmodule

/* tb/async_fifo_tb.sv */
`include "fifo_settings.svh"

module async_fifo_tb;

  import fifo_data_pkg::*;

  localparam int TIMEOUT_CYCLES = 1500;

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  fifo_word_t wr_data;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  fifo_word_t rd_data;
  logic       full;
  logic       empty;
  logic       afull;
  logic       aempty;

  fifo_word_t  model[$];      // words written and not yet read, oldest first
  fifo_word_t  rd_expect;
  logic        rd_pending;    // a read was issued and its word is checked next cycle
  int          error_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state = 32'd89;

  tb_clocks clocks_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n)
  );

  async_fifo async_fifo_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  always @(posedge rd_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d rd_clk cycles, the tests did not finish", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic note_error(input string msg);
    $display("[ERROR] time %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_word(input string name, input fifo_word_t got, input fifo_word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // full seen here is what the DUT uses at the next wr_clk edge
  task automatic write_cycle(input logic en, input fifo_word_t data, output logic seen_full);
    @(posedge wr_clk);
    #5;
    seen_full = full;
    wr_en = en;
    wr_data = data;
    if (en && !full) begin
      if (model.size() >= `FIFO_DEPTH) begin
        note_error("write accepted while the reference model already held a full FIFO");
      end
      model.push_back(data);
    end
  endtask

  task automatic read_cycle(input logic en);
    @(posedge rd_clk);
    #5;
    if (rd_pending) begin
      check_word("rd_data", rd_data, rd_expect);
      rd_pending = 1'b0;
    end
    rd_en = en;
    if (en && !empty) begin
      if (model.size() == 0) begin
        note_error("read accepted while the reference model held no words");
      end else begin
        rd_expect = model.pop_front();
        rd_pending = 1'b1;
      end
    end
  endtask

  task automatic settle();
    repeat (6) @(posedge rd_clk);
    #5;
  endtask

  task automatic wait_not_empty(input int limit);
    int n;
    n = 0;
    @(posedge rd_clk);
    #5;
    while (empty && n < limit) begin
      @(posedge rd_clk);
      #5;
      n++;
    end
    if (empty) begin
      note_error("empty stayed high after a write");
    end
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    while (model.size() > 0 && n < limit) begin
      read_cycle(1'b1);
      n++;
    end
    read_cycle(1'b0);
    if (model.size() > 0) begin
      note_error("FIFO did not drain, words are left in the reference model");
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = error_count;
    @(posedge rd_clk);
    #5;
    check_flag("empty", empty, 1'b1);
    check_flag("aempty", aempty, 1'b1);
    check_flag("full", full, 1'b0);
    check_flag("afull", afull, 1'b0);
    check_word("rd_data", rd_data, '0);
    report_test("reset", errs);
  endtask

  task automatic test_order();
    int   errs;
    logic seen;
    errs = error_count;
    repeat (6) write_cycle(1'b1, fifo_word_t'(next_rand()), seen);
    write_cycle(1'b0, '0, seen);
    wait_not_empty(10);
    drain(40);
    report_test("order", errs);
  endtask

  task automatic test_full_drop();
    int   errs;
    int   dropped;
    logic seen;
    logic exp_full;
    errs = error_count;
    dropped = 0;
    settle();
    repeat (20) begin
      exp_full = (model.size() >= `FIFO_DEPTH);  // nothing is read, so every accepted word stays
      write_cycle(1'b1, fifo_word_t'(next_rand()), seen);
      check_flag("full", seen, exp_full);
      if (seen) begin
        dropped++;
      end
    end
    write_cycle(1'b0, '0, seen);
    check_flag("full", seen, 1'b1);
    if (model.size() != `FIFO_DEPTH || dropped != 4) begin
      note_error("writes made while full changed the number of stored words");
    end
    wait_not_empty(10);
    drain(60);
    report_test("full_drop", errs);
  endtask

  task automatic test_thresholds();
    int   errs;
    logic seen;
    errs = error_count;
    settle();
    repeat (14) begin
      write_cycle(1'b1, fifo_word_t'(next_rand()), seen);
      write_cycle(1'b0, '0, seen);
      check_flag("afull", afull, model.size() >= `FIFO_AFULL);
      check_flag("full", full, 1'b0);
    end
    settle();
    check_flag("aempty", aempty, 1'b0);
    repeat (12) begin
      read_cycle(1'b1);
      read_cycle(1'b0);
      check_flag("aempty", aempty, model.size() <= `FIFO_AEMPTY);
    end
    settle();
    check_flag("aempty", aempty, 1'b1);
    check_flag("afull", afull, 1'b0);
    drain(20);
    report_test("thresholds", errs);
  endtask

  task automatic test_read_empty();
    int         errs;
    logic       seen;
    fifo_word_t fresh;
    errs = error_count;
    settle();
    check_flag("empty", empty, 1'b1);
    repeat (3) read_cycle(1'b1);
    read_cycle(1'b0);
    check_word("rd_data", rd_data, rd_expect);  // still the last word read
    fresh = ~rd_expect;
    write_cycle(1'b1, fresh, seen);
    write_cycle(1'b0, '0, seen);
    wait_not_empty(10);
    drain(20);
    report_test("read_empty", errs);
  endtask

  task automatic test_traffic();
    int          errs;
    logic        seen;
    logic [31:0] r_wr;
    logic [31:0] r_rd;
    errs = error_count;
    // the FIFO fills up in the first half and runs dry in the second
    fork
      begin
        for (int i = 0; i < 280; i++) begin
          r_wr = next_rand();
          write_cycle((i < 140) ? r_wr[0] : (r_wr[0] & r_wr[1]), fifo_word_t'(r_wr >> 8), seen);
        end
        write_cycle(1'b0, '0, seen);
      end
      begin
        for (int i = 0; i < 200; i++) begin
          r_rd = next_rand();
          read_cycle((i < 100) ? (r_rd[1] & r_rd[2]) : (r_rd[1] | r_rd[2]));
        end
        read_cycle(1'b0);
      end
    join
    drain(60);
    report_test("traffic", errs);
  endtask

  initial begin
    wr_en = 1'b0;
    wr_data = '0;
    rd_en = 1'b0;
    rd_pending = 1'b0;
    rd_expect = '0;
    wait (wr_rst_n && rd_rst_n);
    test_reset();
    test_order();
    test_full_drop();
    test_thresholds();
    test_read_empty();
    test_traffic();
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+design
design/fifo_ptr_pkg.sv
design/fifo_data_pkg.sv
design/dual_port_ram.sv
design/gray_ptr_counter.sv
design/wr_flag_logic.sv
design/rd_flag_logic.sv
design/async_fifo.sv
tb/tb_clocks.sv
tb/async_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module async_fifo_tb -f build.f -o async_fifo_sim &&
sim_out="$(./obj_dir/async_fifo_sim)"
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{
  echo "simulation failed"
  exit 1
}
